// File: Makefile
# Verilator build and run for the int-to-float converter.

VERILATOR ?= verilator
TOP       ?= i2f_tb
FILELIST  ?= i2f_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ns

SRCS := $(wildcard common/*.sv design/*.sv tests/*.sv)
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/i2f_cfg.svh
//##################################################
// Int-to-float configuration
// Operand and IEEE-754 single-precision field widths.
//##################################################

`ifndef I2F_CFG_SVH
`define I2F_CFG_SVH

// Integer operand width.
`define I2F_INT_W 32

// Stored fraction width; the normalized mantissa is one bit wider.
`define FP_FRAC_W 23

// Exponent field width and bias.
`define FP_EXP_W 8
`define FP_EXP_BIAS 127

`endif

// File: common/i2f_pkg.sv
//##################################################
// Int-to-float shared types
// Rounding modes, operand views and stage payloads.
//##################################################

`default_nettype none

`include "i2f_cfg.svh"

package i2f_pkg;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rm_e;

    // Two's complement view of the operand.
    typedef struct packed {
        logic                   sign;
        logic [`I2F_INT_W-2:0]  low;
    } int_signed_t;

    typedef union packed {
        logic [`I2F_INT_W-1:0]  mag;
        int_signed_t            s;
    } int_operand_u;

    // One normalized value with the leading one at mant MSB.
    typedef struct packed {
        logic                   sign;
        logic                   zero;
        logic [`FP_EXP_W-1:0]   exp;
        logic [`FP_FRAC_W:0]    mant;
        logic                   guard;
        logic                   rnd;
        logic                   sticky;
    } norm_t;

    typedef struct packed {
        logic                   sign;
        logic [`FP_EXP_W-1:0]   exp;
        logic [`FP_FRAC_W-1:0]  frac;
    } fp32_t;

endpackage

`default_nettype wire

// File: design/i2f_normalize.sv
//##################################################
// Int-to-float normalizer
// Takes sign and magnitude of a strobed operand and
// shifts it left one bit per clock until the leading
// one sits at the top of the mantissa.
//##################################################

`timescale 1ns/1ns
`default_nettype none

`include "i2f_cfg.svh"

module i2f_normalize (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_stb,
    input  i2f_pkg::int_operand_u operand,
    input  logic                  is_signed,
    input  i2f_pkg::rm_e          rm,
    output logic                  busy,
    output logic                  norm_stb,
    output i2f_pkg::norm_t        norm,
    output i2f_pkg::rm_e          norm_rm
);

    localparam int MANT_W = `FP_FRAC_W + 1;
    localparam int REM_W  = `I2F_INT_W - MANT_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT,
        ST_DONE
    } state_e;

    state_e                 state;
    logic                   accept;
    logic                   neg;
    logic [`I2F_INT_W-1:0]  mag_in;

    logic                   sign_q;
    logic                   zero_q;
    logic [`FP_EXP_W-1:0]   exp_q;
    logic [MANT_W-1:0]      mant_q;
    logic [REM_W-1:0]       rem_q;

    // A new operand is taken in idle or while the last one hands off.
    assign busy     = (state == ST_LOAD) || (state == ST_SHIFT);
    assign norm_stb = (state == ST_DONE);
    assign accept   = in_stb && !busy;

    // Sign bit only counts for signed operations.
    assign neg    = is_signed && operand.s.sign;
    assign mag_in = neg ? -operand.mag : operand.mag;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_stb)
                        state <= ST_LOAD;
                end
                ST_LOAD: begin
                    if (zero_q || mant_q[MANT_W-1])
                        state <= ST_DONE;
                    else
                        state <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    // Bit below the top becomes the leading one after this shift.
                    if (mant_q[MANT_W-2])
                        state <= ST_DONE;
                end
                ST_DONE: begin
                    state <= in_stb ? ST_LOAD : ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Load on the accepting edge, with the exponent at the operand MSB.
    always_ff @(posedge clk) begin
        if (accept) begin
            sign_q  <= neg;
            zero_q  <= (mag_in == '0);
            exp_q   <= `FP_EXP_W'(`I2F_INT_W - 1);
            mant_q  <= mag_in[`I2F_INT_W-1 -: MANT_W];
            rem_q   <= mag_in[REM_W-1:0];
            norm_rm <= rm;
        end else if (state == ST_SHIFT) begin
            exp_q  <= exp_q - 1'b1;
            mant_q <= {mant_q[MANT_W-2:0], rem_q[REM_W-1]};
            rem_q  <= {rem_q[REM_W-2:0], 1'b0};
        end
    end

    always_comb begin
        norm.sign   = sign_q;
        norm.zero   = zero_q;
        norm.exp    = exp_q;
        norm.mant   = mant_q;
        norm.guard  = rem_q[REM_W-1];
        norm.rnd    = rem_q[REM_W-2];
        norm.sticky = |rem_q[REM_W-3:0];
    end

    // Source must respect busy.
    a_no_stb_when_busy: assert property (
        @(posedge clk) disable iff (!rst) !(in_stb && busy));

    // Handoff always carries a normalized mantissa.
    a_norm_msb: assert property (
        @(posedge clk) disable iff (!rst)
        (norm_stb && !norm.zero) |-> norm.mant[MANT_W-1]);

endmodule

`default_nettype wire

// File: design/i2f_round.sv
//##################################################
// Int-to-float rounding stage
// Applies the rounding mode, renormalizes on carry
// and registers the packed float with inexact.
//##################################################

`timescale 1ns/1ns
`default_nettype none

`include "i2f_cfg.svh"

module i2f_round (
    input  logic           clk,
    input  logic           rst,
    input  logic           norm_stb,
    input  i2f_pkg::norm_t norm,
    input  i2f_pkg::rm_e   norm_rm,
    output i2f_pkg::fp32_t result,
    output logic           inexact,
    output logic           out_stb
);

    localparam int MANT_W = `FP_FRAC_W + 1;

    logic                   dropped;
    logic                   round_up;
    logic [MANT_W:0]        mant_sum;
    logic                   carry;
    logic [`FP_FRAC_W-1:0]  frac;
    logic [`FP_EXP_W-1:0]   exp_b;
    i2f_pkg::fp32_t         packed_fp;

    assign dropped = norm.guard || norm.rnd || norm.sticky;

    always_comb begin
        case (norm_rm)
            i2f_pkg::RTZ: round_up = 1'b0;
            i2f_pkg::RDN: round_up = dropped && norm.sign;
            i2f_pkg::RUP: round_up = dropped && !norm.sign;
            i2f_pkg::RMM: round_up = norm.guard;
            // RNE is also the fallback for the reserved codes.
            default: round_up = norm.guard && (norm.rnd || norm.sticky || norm.mant[0]);
        endcase
    end

    // One extra bit catches the all-ones carry-out.
    assign mant_sum = {1'b0, norm.mant} + (MANT_W + 1)'(round_up);
    assign carry    = mant_sum[MANT_W];
    assign frac     = carry ? mant_sum[MANT_W-1:1] : mant_sum[`FP_FRAC_W-1:0];
    assign exp_b    = norm.exp + `FP_EXP_W'(carry) + `FP_EXP_W'(`FP_EXP_BIAS);

    always_comb begin
        if (norm.zero) begin
            packed_fp = '0;
        end else begin
            packed_fp.sign = norm.sign;
            packed_fp.exp  = exp_b;
            packed_fp.frac = frac;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_stb <= 1'b0;
            result  <= '0;
            inexact <= 1'b0;
        end else begin
            out_stb <= norm_stb;
            if (norm_stb) begin
                result  <= packed_fp;
                inexact <= dropped && !norm.zero;
            end
        end
    end

    // Normalizer never hands off on back-to-back cycles.
    a_out_stb_pulse: assert property (
        @(posedge clk) disable iff (!rst) out_stb |=> !out_stb);

endmodule

`default_nettype wire

// File: design/i2f_top.sv
//##################################################
// Int-to-float converter top
// Normalizer feeding a registered rounding stage.
//##################################################

`timescale 1ns/1ns
`default_nettype none

module i2f_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_stb,
    input  i2f_pkg::int_operand_u operand,
    input  logic                  is_signed,
    input  i2f_pkg::rm_e          rm,
    output logic                  busy,
    output i2f_pkg::fp32_t        result,
    output logic                  inexact,
    output logic                  out_stb
);

    // Handoff between the two stages.
    logic           norm_stb;
    i2f_pkg::norm_t norm;
    i2f_pkg::rm_e   norm_rm;

    i2f_normalize i2f_normalize_inst (
        .clk       (clk),
        .rst       (rst),
        .in_stb    (in_stb),
        .operand   (operand),
        .is_signed (is_signed),
        .rm        (rm),
        .busy      (busy),
        .norm_stb  (norm_stb),
        .norm      (norm),
        .norm_rm   (norm_rm)
    );

    i2f_round i2f_round_inst (
        .clk      (clk),
        .rst      (rst),
        .norm_stb (norm_stb),
        .norm     (norm),
        .norm_rm  (norm_rm),
        .result   (result),
        .inexact  (inexact),
        .out_stb  (out_stb)
    );

endmodule

`default_nettype wire

// File: i2f_top.f
+incdir+common
common/i2f_pkg.sv
design/i2f_normalize.sv
design/i2f_round.sv
design/i2f_top.sv
tests/i2f_checker.sv
tests/i2f_tb.sv

// File: tests/i2f_checker.sv
//##################################################
// Int-to-float checker
// Models each accepted conversion and compares it
// with the DUT result, one report line per test.
//##################################################

`timescale 1ns/1ns
`default_nettype none

`include "i2f_cfg.svh"

module i2f_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_stb,
    input  logic [`I2F_INT_W-1:0] operand,
    input  logic                  is_signed,
    input  logic [2:0]            rm,
    input  logic                  busy,
    input  logic [`I2F_INT_W-1:0] result,
    input  logic                  inexact,
    input  logic                  out_stb,
    input  logic                  expect_valid,
    input  logic [`I2F_INT_W-1:0] expect_result,
    input  logic                  expect_inexact,
    output int                    done_count,
    output int                    pass_count,
    output int                    fail_count
);

    // One accepted operand waiting for its result.
    typedef struct packed {
        logic [`I2F_INT_W-1:0] operand;
        logic                  sgn;
        logic [2:0]            mode;
        logic                  expect_valid;
        logic [`I2F_INT_W:0]   expect_word;
        logic [`I2F_INT_W:0]   model;
    } pend_t;

    pend_t                 pend_q[$];
    pend_t                 incoming;
    pend_t                 head;
    logic [`I2F_INT_W:0]   want;
    logic                  ok;
    // Set for the cycle after an accepted operand.
    logic                  accepted_q;

    // Conversion by value. Finds the leading one, then rounds the dropped bits.
    // Returns {inexact, float word}.
    function automatic logic [`I2F_INT_W:0] convert_int(
        input logic [`I2F_INT_W-1:0] op,
        input logic                  sgn,
        input logic [2:0]            mode
    );
        logic                  neg;
        logic [`I2F_INT_W-1:0] mag;
        logic [63:0]           kept;
        logic [63:0]           rest;
        logic [63:0]           half;
        logic                  up;
        int                    b;
        int                    p;
        int                    e;
        neg = sgn && op[`I2F_INT_W-1];
        mag = neg ? (~op + 1'b1) : op;
        if (mag == '0)
            return '0;
        p = 0;
        for (b = 0; b < `I2F_INT_W; b++) begin
            if (mag[b])
                p = b;
        end
        e = p + `FP_EXP_BIAS;
        if (p <= `FP_FRAC_W) begin
            kept = {32'd0, mag} << (`FP_FRAC_W - p);
            rest = '0;
            half = '0;
        end else begin
            kept = {32'd0, mag} >> (p - `FP_FRAC_W);
            rest = {32'd0, mag} & ((64'd1 << (p - `FP_FRAC_W)) - 64'd1);
            half = 64'd1 << (p - `FP_FRAC_W - 1);
        end
        case (mode)
            3'd1: up = 1'b0;
            3'd2: up = (rest != '0) && neg;
            3'd3: up = (rest != '0) && !neg;
            3'd4: up = (rest != '0) && (rest >= half);
            // Nearest even is also used for the reserved codes.
            default: up = (rest > half) || ((rest != '0) && (rest == half) && kept[0]);
        endcase
        kept = kept + 64'(up);
        if (kept[`FP_FRAC_W+1]) begin
            kept = kept >> 1;
            e = e + 1;
        end
        return {rest != '0, neg, `FP_EXP_W'(e), kept[`FP_FRAC_W-1:0]};
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            pend_q.delete();
            accepted_q = 1'b0;
            done_count = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            // The normalizer turns busy on right after it takes an operand.
            if (accepted_q && busy !== 1'b1) begin
                $display("MISMATCH at %0t: busy got %b expected 1", $time, busy);
                fail_count++;
            end
            accepted_q = in_stb && !busy;
            if (in_stb && !busy) begin
                incoming = '{operand, is_signed, rm, expect_valid,
                             {expect_inexact, expect_result},
                             convert_int(operand, is_signed, rm)};
                pend_q.push_back(incoming);
            end
            if (out_stb) begin
                if (pend_q.size() == 0) begin
                    $display("ERROR at %0t: out_stb pulsed with no operand outstanding", $time);
                    fail_count++;
                end else begin
                    head = pend_q.pop_front();
                    want = head.expect_valid ? head.expect_word : head.model;
                    ok = 1'b1;
                    if (head.expect_valid && (head.expect_word != head.model)) begin
                        $display("ERROR at %0t: table value %h disagrees with model value %h",
                                 $time, head.expect_word, head.model);
                        ok = 1'b0;
                    end
                    if (result !== want[`I2F_INT_W-1:0]) begin
                        $display("MISMATCH at %0t: result got %h expected %h",
                                 $time, result, want[`I2F_INT_W-1:0]);
                        ok = 1'b0;
                    end
                    if (inexact !== want[`I2F_INT_W]) begin
                        $display("MISMATCH at %0t: inexact got %b expected %b",
                                 $time, inexact, want[`I2F_INT_W]);
                        ok = 1'b0;
                    end
                    done_count++;
                    if (ok)
                        pass_count++;
                    else
                        fail_count++;
                    $display("test %0d: operand %h signed %0d rm %0d result %h inexact %0d %s",
                             done_count, head.operand, head.sgn, head.mode, result, inexact,
                             ok ? "ok" : "fail");
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/i2f_tb.sv
//##################################################
// Int-to-float testbench
// Directed and random conversions applied from a
// table, checked by the checker module.
//##################################################

`timescale 1ns/1ns
`default_nettype none

`include "i2f_cfg.svh"

module i2f_tb;

    localparam int N_RANDOM   = 40;
    localparam int BUSY_LIMIT = 50;
    localparam int DONE_LIMIT = 60;

    typedef struct packed {
        logic [`I2F_INT_W-1:0] operand;
        logic                  sgn;
        logic [2:0]            mode;
        logic                  chain;
        logic                  checked;
        logic [`I2F_INT_W-1:0] exp_result;
        logic                  exp_inexact;
    } entry_t;

    logic                  clk;
    logic                  rst;
    logic                  in_stb;
    i2f_pkg::int_operand_u operand;
    logic                  is_signed;
    i2f_pkg::rm_e          rm;
    logic                  busy;
    i2f_pkg::fp32_t        result;
    logic                  inexact;
    logic                  out_stb;

    logic                  expect_valid;
    logic [`I2F_INT_W-1:0] expect_result;
    logic                  expect_inexact;
    int                    done_count;
    int                    pass_count;
    int                    fail_count;

    entry_t                stim[$];
    integer                seed;
    logic                  chain_next;
    logic                  timed_out;
    int                    sent;
    int                    i;

    i2f_top i2f_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_stb    (in_stb),
        .operand   (operand),
        .is_signed (is_signed),
        .rm        (rm),
        .busy      (busy),
        .result    (result),
        .inexact   (inexact),
        .out_stb   (out_stb)
    );

    i2f_checker i2f_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .in_stb         (in_stb),
        .operand        (operand),
        .is_signed      (is_signed),
        .rm             (rm),
        .busy           (busy),
        .result         (result),
        .inexact        (inexact),
        .out_stb        (out_stb),
        .expect_valid   (expect_valid),
        .expect_result  (expect_result),
        .expect_inexact (expect_inexact),
        .done_count     (done_count),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_directed(input logic [`I2F_INT_W-1:0] op, input logic sgn,
                                input logic [2:0] mode, input logic [`I2F_INT_W-1:0] res,
                                input logic inx);
        entry_t e;
        e = '{op, sgn, mode, chain_next, 1'b1, res, inx};
        chain_next = 1'b0;
        stim.push_back(e);
    endtask

    task automatic add_random(input logic [`I2F_INT_W-1:0] op, input logic sgn,
                              input logic [2:0] mode);
        entry_t e;
        e = '{op, sgn, mode, 1'b0, 1'b0, '0, 1'b0};
        stim.push_back(e);
    endtask

    task automatic build_table();
        int          m;
        logic [31:0] word;
        logic [31:0] amount;
        logic [31:0] ctl;
        // Zero in every mode and both signedness settings.
        for (m = 0; m < 5; m++) begin
            add_directed(32'h0, 1'b1, 3'(m), 32'h0, 1'b0);
            add_directed(32'h0, 1'b0, 3'(m), 32'h0, 1'b0);
        end
        add_directed(32'h0000_0001, 1'b1, i2f_pkg::RNE, 32'h3F80_0000, 1'b0);
        add_directed(32'hFFFF_FFFF, 1'b1, i2f_pkg::RTZ, 32'hBF80_0000, 1'b0);
        add_directed(32'h0100_0000, 1'b0, i2f_pkg::RDN, 32'h4B80_0000, 1'b0);
        add_directed(32'h00FF_FFFF, 1'b0, i2f_pkg::RUP, 32'h4B7F_FFFF, 1'b0);
        add_directed(32'h8000_0000, 1'b1, i2f_pkg::RMM, 32'hCF00_0000, 1'b0);
        add_directed(32'h8000_0000, 1'b0, i2f_pkg::RNE, 32'h4F00_0000, 1'b0);
        // Exact tie between two neighbours.
        add_directed(32'h0100_0001, 1'b0, i2f_pkg::RNE, 32'h4B80_0000, 1'b1);
        add_directed(32'h0100_0001, 1'b0, i2f_pkg::RTZ, 32'h4B80_0000, 1'b1);
        add_directed(32'h0100_0001, 1'b0, i2f_pkg::RDN, 32'h4B80_0000, 1'b1);
        add_directed(32'h0100_0001, 1'b0, i2f_pkg::RUP, 32'h4B80_0001, 1'b1);
        add_directed(32'h0100_0001, 1'b0, i2f_pkg::RMM, 32'h4B80_0001, 1'b1);
        add_directed(32'h0100_0003, 1'b0, i2f_pkg::RNE, 32'h4B80_0002, 1'b1);
        add_directed(32'h0100_0003, 1'b0, i2f_pkg::RTZ, 32'h4B80_0001, 1'b1);
        add_directed(32'h0100_0003, 1'b0, 3'd5, 32'h4B80_0002, 1'b1);
        add_directed(32'hFEFF_FFFF, 1'b1, i2f_pkg::RNE, 32'hCB80_0000, 1'b1);
        add_directed(32'hFEFF_FFFF, 1'b1, i2f_pkg::RDN, 32'hCB80_0001, 1'b1);
        add_directed(32'hFEFF_FFFF, 1'b1, i2f_pkg::RUP, 32'hCB80_0000, 1'b1);
        add_directed(32'hFEFF_FFFF, 1'b1, i2f_pkg::RMM, 32'hCB80_0001, 1'b1);
        // Mantissa carry-out.
        add_directed(32'hFFFF_FFFF, 1'b0, i2f_pkg::RNE, 32'h4F80_0000, 1'b1);
        add_directed(32'hFFFF_FFFF, 1'b0, i2f_pkg::RTZ, 32'h4F7F_FFFF, 1'b1);
        // Chained operands sent as soon as busy falls.
        chain_next = 1'b1;
        add_directed(32'h0000_0003, 1'b0, i2f_pkg::RNE, 32'h4040_0000, 1'b0);
        chain_next = 1'b1;
        add_directed(32'hFFFF_FFFF, 1'b1, i2f_pkg::RNE, 32'hBF80_0000, 1'b0);
        add_directed(32'h7FFF_FFFF, 1'b1, i2f_pkg::RTZ, 32'h4EFF_FFFF, 1'b1);
        // Random words shifted to spread the leading-zero count.
        for (m = 0; m < N_RANDOM; m++) begin
            word   = $random(seed);
            amount = $random(seed);
            ctl    = $random(seed);
            add_random(word >> amount[4:0], ctl[3], 3'(ctl[7:4] % 4'd5));
        end
    endtask

    task automatic wait_idle(output logic expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (busy && !expired) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= BUSY_LIMIT && busy)
                expired = 1'b1;
        end
        if (expired)
            $display("ERROR at %0t: busy stayed high for %0d cycles", $time, BUSY_LIMIT);
    endtask

    task automatic wait_results(input int target, output logic expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (done_count < target && !expired) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= DONE_LIMIT && done_count < target)
                expired = 1'b1;
        end
        if (expired)
            $display("ERROR at %0t: only %0d of %0d results arrived within %0d cycles",
                     $time, done_count, target, DONE_LIMIT);
    endtask

    // Called 1 ns after a rising edge with busy low.
    task automatic send_entry(input entry_t e);
        operand.mag    = e.operand;
        is_signed      = e.sgn;
        rm             = i2f_pkg::rm_e'(e.mode);
        expect_valid   = e.checked;
        expect_result  = e.exp_result;
        expect_inexact = e.exp_inexact;
        in_stb         = 1'b1;
        @(posedge clk);
        #1;
        in_stb       = 1'b0;
        expect_valid = 1'b0;
    endtask

    initial begin
        seed           = 32'hc0ab8887;
        rst            = 1'b0;
        in_stb         = 1'b0;
        operand.mag    = '0;
        is_signed      = 1'b0;
        rm             = i2f_pkg::RNE;
        expect_valid   = 1'b0;
        expect_result  = '0;
        expect_inexact = 1'b0;
        chain_next     = 1'b0;
        timed_out      = 1'b0;
        sent           = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (i = 0; i < stim.size() && !timed_out; i++) begin
            wait_idle(timed_out);
            if (!timed_out) begin
                send_entry(stim[i]);
                sent++;
                if (!stim[i].chain)
                    wait_results(sent, timed_out);
            end
        end
        if (!timed_out)
            wait_results(sent, timed_out);
        $display("summary: %0d of %0d tests done, %0d passed, %0d failed",
                 done_count, stim.size(), pass_count, fail_count);
        if (timed_out || fail_count != 0 || done_count != stim.size())
            $display("CHECKS FAILED");
        else
            $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
